// ==== design/game_pkg.sv ====
`default_nettype none

package game_pkg;

  // widths
  parameter int COORD_W = 11;  // pixel coordinates and counters
  parameter int RGB_W   = 12;  // 4:4:4 color
  parameter int LEVEL_W = 4;

  // screen geometry
  parameter int X_MIN   = 16;   // left bounce limit for the enemy left edge
  parameter int X_MAX   = 960;  // right bounce limit
  parameter int Y_LIMIT = 768;  // enemy missile leaves the screen here
  parameter int ROW_GAP = 64;   // enemy N has its top at N * ROW_GAP

  parameter int MISSILE_STEP = 8;  // pixels per frame

  // APB word addresses of the register block
  typedef enum logic [7:0] {
    REG_CTRL   = 8'h00,  // bit 0 run
    REG_COLOR  = 8'h04,  // sprite color
    REG_SPEED  = 8'h08,  // base speed in 4 bits
    REG_STATUS = 8'h0C   // read only with alive in 2:0 and level in 7:4
  } reg_addr_e;

  // per-enemy life state
  typedef enum logic {
    EN_ALIVE = 1'b0,
    EN_DEAD  = 1'b1
  } enemy_state_e;

endpackage

`default_nettype wire

// ==== design/enemy_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module enemy_regs (
  input  wire                             pclk,
  input  wire                             rst_n_i,

  // APB3 slave
  input  wire                             psel_i,
  input  wire                             penable_i,
  input  wire                             pwrite_i,
  input  wire  [7:0]                      paddr_i,
  input  wire  [31:0]                     pwdata_i,
  output logic [31:0]                     prdata_o,
  output logic                            pready_o,
  output logic                            pslverr_o,

  // status from the enemy layer
  input  wire  [2:0]                      alive_i,
  input  wire  [game_pkg::LEVEL_W-1:0]    level_i,

  // controls to the enemy layer
  output logic                            run_o,
  output logic [game_pkg::RGB_W-1:0]      color_o,
  output logic [3:0]                      speed_o
);

  logic        access;    // second cycle of a transfer
  logic        addr_ok;
  logic        ro_write;  // write aimed at the status word
  logic [31:0] rdata;

  assign access   = psel_i & penable_i;
  assign ro_write = pwrite_i & (paddr_i == game_pkg::REG_STATUS);

  // address decode and read mux
  always_comb begin
    addr_ok = 1'b1;
    rdata   = '0;
    case (paddr_i)
      game_pkg::REG_CTRL: begin
        rdata[0] = run_o;
      end
      game_pkg::REG_COLOR: begin
        rdata[game_pkg::RGB_W-1:0] = color_o;
      end
      game_pkg::REG_SPEED: begin
        rdata[3:0] = speed_o;
      end
      game_pkg::REG_STATUS: begin
        rdata[2:0] = alive_i;
        rdata[7:4] = level_i;
      end
      default: begin
        addr_ok = 1'b0;
      end
    endcase
  end

  assign prdata_o  = access ? rdata : '0;
  assign pready_o  = 1'b1;  // no wait states
  assign pslverr_o = access & (~addr_ok | ro_write);

  // writable registers update at the end of the access cycle
  always_ff @(posedge pclk) begin
    if (!rst_n_i) begin
      run_o   <= 1'b0;
      color_o <= 12'hF00;  // red
      speed_o <= 4'd1;
    end else if (access && pwrite_i && addr_ok) begin
      case (paddr_i)
        game_pkg::REG_CTRL:  run_o   <= pwdata_i[0];
        game_pkg::REG_COLOR: color_o <= pwdata_i[game_pkg::RGB_W-1:0];
        game_pkg::REG_SPEED: speed_o <= pwdata_i[3:0];
        default: begin
          // status is read only and flagged above
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== design/enemy_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module enemy_unit #(
  parameter int IDX        = 1,
  parameter int ENEMY_SIZE = 32
) (
  input  wire                            pclk,
  input  wire                            rst_n_i,

  // video in
  input  wire  [game_pkg::COORD_W-1:0]   vcount_i,
  input  wire                            vsync_i,
  input  wire                            vblnk_i,
  input  wire  [game_pkg::COORD_W-1:0]   hcount_i,
  input  wire                            hsync_i,
  input  wire                            hblnk_i,
  input  wire  [game_pkg::RGB_W-1:0]     rgb_i,

  // video out one stage later
  output logic [game_pkg::COORD_W-1:0]   vcount_o,
  output logic                           vsync_o,
  output logic                           vblnk_o,
  output logic [game_pkg::COORD_W-1:0]   hcount_o,
  output logic                           hsync_o,
  output logic                           hblnk_o,
  output logic [game_pkg::RGB_W-1:0]     rgb_o,

  // player missile
  input  wire  [game_pkg::COORD_W-1:0]   xpos_missile_i,
  input  wire  [game_pkg::COORD_W-1:0]   ypos_missile_i,
  input  wire                            on_missile_i,

  input  wire                            run_i,
  input  wire  [game_pkg::RGB_W-1:0]     color_i,
  input  wire  [3:0]                     speed_i,
  input  wire  [game_pkg::LEVEL_W-1:0]   level_i,
  input  wire                            respawn_i,

  output logic                           alive_o,
  output logic [game_pkg::COORD_W-1:0]   en_x_missile_o,
  output logic [game_pkg::COORD_W-1:0]   en_y_missile_o
);

  localparam int CW = game_pkg::COORD_W;

  localparam logic [CW-1:0] START_X = CW'(IDX * 200);
  localparam logic [CW-1:0] TOP_Y   = CW'(IDX * game_pkg::ROW_GAP);
  localparam logic [CW-1:0] SIZE    = CW'(ENEMY_SIZE);
  localparam logic [CW-1:0] HALF    = CW'(ENEMY_SIZE / 2);
  localparam logic [CW-1:0] X_LO    = CW'(game_pkg::X_MIN);
  localparam logic [CW-1:0] X_HI    = CW'(game_pkg::X_MAX);
  localparam logic [CW-1:0] Y_END   = CW'(game_pkg::Y_LIMIT);
  localparam logic [CW-1:0] M_STEP  = CW'(game_pkg::MISSILE_STEP);

  game_pkg::enemy_state_e state_r;

  logic [CW-1:0] x_r;          // left edge
  logic          dir_right_r;
  logic          vblnk_d;

  logic [CW-1:0] step;
  logic [CW-1:0] x_nxt;
  logic          dir_nxt;
  logic [CW-1:0] my_nxt;
  logic          frame_start;
  logic          in_row;
  logic          draw;
  logic          hit;

  assign alive_o     = (state_r == game_pkg::EN_ALIVE);
  assign frame_start = vblnk_i & ~vblnk_d;  // rising edge of vblnk
  assign step        = CW'(speed_i) + CW'(level_i);
  assign my_nxt      = en_y_missile_o + M_STEP;

  assign in_row = (vcount_i >= TOP_Y) && (vcount_i < TOP_Y + SIZE);
  assign draw   = alive_o && in_row && (hcount_i >= x_r) && (hcount_i < x_r + SIZE);

  // player missile point inside the live square
  assign hit = on_missile_i && alive_o &&
               (xpos_missile_i >= x_r) && (xpos_missile_i < x_r + SIZE) &&
               (ypos_missile_i >= TOP_Y) && (ypos_missile_i < TOP_Y + SIZE);

  // horizontal step with bounce and clamp
  always_comb begin
    x_nxt   = x_r + step;
    dir_nxt = dir_right_r;
    if (dir_right_r) begin
      if (x_r + step > X_HI) begin
        x_nxt   = X_HI;
        dir_nxt = 1'b0;
      end
    end else begin
      x_nxt = x_r - step;
      if (x_r < X_LO + step) begin
        x_nxt   = X_LO;
        dir_nxt = 1'b1;
      end
    end
  end

  always_ff @(posedge pclk) begin
    if (!rst_n_i) begin
      vblnk_d <= 1'b0;
    end else begin
      vblnk_d <= vblnk_i;
    end
  end

  // position, life and missile
  always_ff @(posedge pclk) begin
    if (!rst_n_i || respawn_i) begin
      state_r        <= game_pkg::EN_ALIVE;
      x_r            <= START_X;
      dir_right_r    <= 1'b1;
      en_x_missile_o <= START_X + HALF;  // loaded at the centre
      en_y_missile_o <= TOP_Y + SIZE;    // bottom edge
    end else begin
      if (hit) begin
        state_r <= game_pkg::EN_DEAD;
      end
      if (frame_start && run_i) begin
        x_r         <= x_nxt;
        dir_right_r <= dir_nxt;
        if (my_nxt >= Y_END) begin
          en_x_missile_o <= x_r + HALF;  // reload
          en_y_missile_o <= TOP_Y + SIZE;
        end else begin
          en_y_missile_o <= my_nxt;
        end
      end
    end
  end

  // video stage
  always_ff @(posedge pclk) begin
    vcount_o <= vcount_i;
    vsync_o  <= vsync_i;
    vblnk_o  <= vblnk_i;
    hcount_o <= hcount_i;
    hsync_o  <= hsync_i;
    hblnk_o  <= hblnk_i;
    rgb_o    <= draw ? color_i : rgb_i;
  end

endmodule

`default_nettype wire

// ==== design/level_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module level_ctrl (
  input  wire                            pclk,
  input  wire                            rst_n_i,
  input  wire  [2:0]                     alive_i,
  output logic [game_pkg::LEVEL_W-1:0]   level_o,
  output logic                           respawn_o
);

  localparam logic [game_pkg::LEVEL_W-1:0] LEVEL_TOP = '1;

  logic wave_clear;

  // alive bits stay low for one more cycle after the pulse,
  // so the pulse itself blocks a second one
  assign wave_clear = (alive_i == 3'b000) && !respawn_o;

  always_ff @(posedge pclk) begin
    if (!rst_n_i) begin
      level_o   <= '0;
      respawn_o <= 1'b0;
    end else begin
      respawn_o <= wave_clear;
      if (wave_clear && level_o != LEVEL_TOP) begin
        level_o <= level_o + 1'b1;  // saturates at 15
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/enemy_layer.sv ====
`timescale 1ns/1ps
`default_nettype none

module enemy_layer #(
  parameter int ENEMY_SIZE = 32
) (
  input  wire                            pclk,
  input  wire                            rst_n_i,

  input  wire  [game_pkg::COORD_W-1:0]   vcount_i,
  input  wire                            vsync_i,
  input  wire                            vblnk_i,
  input  wire  [game_pkg::COORD_W-1:0]   hcount_i,
  input  wire                            hsync_i,
  input  wire                            hblnk_i,
  input  wire  [game_pkg::RGB_W-1:0]     rgb_i,

  output logic [game_pkg::COORD_W-1:0]   vcount_o,
  output logic                           vsync_o,
  output logic                           vblnk_o,
  output logic [game_pkg::COORD_W-1:0]   hcount_o,
  output logic                           hsync_o,
  output logic                           hblnk_o,
  output logic [game_pkg::RGB_W-1:0]     rgb_o,

  input  wire  [game_pkg::COORD_W-1:0]   xpos_missile_i,
  input  wire  [game_pkg::COORD_W-1:0]   ypos_missile_i,
  input  wire                            on_missile_i,

  input  wire                            run_i,
  input  wire  [game_pkg::RGB_W-1:0]     color_i,
  input  wire  [3:0]                     speed_i,

  output logic [2:0]                     alive_o,
  output logic [game_pkg::LEVEL_W-1:0]   level_o,

  output logic [game_pkg::COORD_W-1:0]   en1_x_missile_o,
  output logic [game_pkg::COORD_W-1:0]   en1_y_missile_o,
  output logic [game_pkg::COORD_W-1:0]   en2_x_missile_o,
  output logic [game_pkg::COORD_W-1:0]   en2_y_missile_o,
  output logic [game_pkg::COORD_W-1:0]   en3_x_missile_o,
  output logic [game_pkg::COORD_W-1:0]   en3_y_missile_o
);

  logic respawn;

  // unit 1 to unit 2
  logic [game_pkg::COORD_W-1:0] vcount_1, hcount_1;
  logic                         vsync_1, vblnk_1, hsync_1, hblnk_1;
  logic [game_pkg::RGB_W-1:0]   rgb_1;

  // unit 2 to unit 3
  logic [game_pkg::COORD_W-1:0] vcount_2, hcount_2;
  logic                         vsync_2, vblnk_2, hsync_2, hblnk_2;
  logic [game_pkg::RGB_W-1:0]   rgb_2;

  enemy_unit #(.IDX(1), .ENEMY_SIZE(ENEMY_SIZE)) enemy_1 (
    .pclk(pclk), .rst_n_i(rst_n_i),
    .vcount_i(vcount_i), .vsync_i(vsync_i), .vblnk_i(vblnk_i),
    .hcount_i(hcount_i), .hsync_i(hsync_i), .hblnk_i(hblnk_i), .rgb_i(rgb_i),
    .vcount_o(vcount_1), .vsync_o(vsync_1), .vblnk_o(vblnk_1),
    .hcount_o(hcount_1), .hsync_o(hsync_1), .hblnk_o(hblnk_1), .rgb_o(rgb_1),
    .xpos_missile_i(xpos_missile_i), .ypos_missile_i(ypos_missile_i),
    .on_missile_i(on_missile_i),
    .run_i(run_i), .color_i(color_i), .speed_i(speed_i),
    .level_i(level_o), .respawn_i(respawn),
    .alive_o(alive_o[0]),
    .en_x_missile_o(en1_x_missile_o), .en_y_missile_o(en1_y_missile_o)
  );

  enemy_unit #(.IDX(2), .ENEMY_SIZE(ENEMY_SIZE)) enemy_2 (
    .pclk(pclk), .rst_n_i(rst_n_i),
    .vcount_i(vcount_1), .vsync_i(vsync_1), .vblnk_i(vblnk_1),
    .hcount_i(hcount_1), .hsync_i(hsync_1), .hblnk_i(hblnk_1), .rgb_i(rgb_1),
    .vcount_o(vcount_2), .vsync_o(vsync_2), .vblnk_o(vblnk_2),
    .hcount_o(hcount_2), .hsync_o(hsync_2), .hblnk_o(hblnk_2), .rgb_o(rgb_2),
    .xpos_missile_i(xpos_missile_i), .ypos_missile_i(ypos_missile_i),
    .on_missile_i(on_missile_i),
    .run_i(run_i), .color_i(color_i), .speed_i(speed_i),
    .level_i(level_o), .respawn_i(respawn),
    .alive_o(alive_o[1]),
    .en_x_missile_o(en2_x_missile_o), .en_y_missile_o(en2_y_missile_o)
  );

  // last stage drives the layer outputs
  enemy_unit #(.IDX(3), .ENEMY_SIZE(ENEMY_SIZE)) enemy_3 (
    .pclk(pclk), .rst_n_i(rst_n_i),
    .vcount_i(vcount_2), .vsync_i(vsync_2), .vblnk_i(vblnk_2),
    .hcount_i(hcount_2), .hsync_i(hsync_2), .hblnk_i(hblnk_2), .rgb_i(rgb_2),
    .vcount_o(vcount_o), .vsync_o(vsync_o), .vblnk_o(vblnk_o),
    .hcount_o(hcount_o), .hsync_o(hsync_o), .hblnk_o(hblnk_o), .rgb_o(rgb_o),
    .xpos_missile_i(xpos_missile_i), .ypos_missile_i(ypos_missile_i),
    .on_missile_i(on_missile_i),
    .run_i(run_i), .color_i(color_i), .speed_i(speed_i),
    .level_i(level_o), .respawn_i(respawn),
    .alive_o(alive_o[2]),
    .en_x_missile_o(en3_x_missile_o), .en_y_missile_o(en3_y_missile_o)
  );

  level_ctrl level_ctrl_i (
    .pclk(pclk),
    .rst_n_i(rst_n_i),
    .alive_i(alive_o),
    .level_o(level_o),
    .respawn_o(respawn)  // back to all three units
  );

endmodule

`default_nettype wire

// ==== design/enemy_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module enemy_top #(
  parameter int ENEMY_SIZE = 32
) (
  input  wire                            pclk,
  input  wire                            rst_n_i,

  // APB3
  input  wire                            psel_i,
  input  wire                            penable_i,
  input  wire                            pwrite_i,
  input  wire  [7:0]                     paddr_i,
  input  wire  [31:0]                    pwdata_i,
  output logic [31:0]                    prdata_o,
  output logic                           pready_o,
  output logic                           pslverr_o,

  // video
  input  wire  [game_pkg::COORD_W-1:0]   vcount_i,
  input  wire                            vsync_i,
  input  wire                            vblnk_i,
  input  wire  [game_pkg::COORD_W-1:0]   hcount_i,
  input  wire                            hsync_i,
  input  wire                            hblnk_i,
  input  wire  [game_pkg::RGB_W-1:0]     rgb_i,
  output logic [game_pkg::COORD_W-1:0]   vcount_o,
  output logic                           vsync_o,
  output logic                           vblnk_o,
  output logic [game_pkg::COORD_W-1:0]   hcount_o,
  output logic                           hsync_o,
  output logic                           hblnk_o,
  output logic [game_pkg::RGB_W-1:0]     rgb_o,

  // player missile
  input  wire  [game_pkg::COORD_W-1:0]   xpos_missile_i,
  input  wire  [game_pkg::COORD_W-1:0]   ypos_missile_i,
  input  wire                            on_missile_i,

  output logic [game_pkg::COORD_W-1:0]   en1_x_missile_o,
  output logic [game_pkg::COORD_W-1:0]   en1_y_missile_o,
  output logic [game_pkg::COORD_W-1:0]   en2_x_missile_o,
  output logic [game_pkg::COORD_W-1:0]   en2_y_missile_o,
  output logic [game_pkg::COORD_W-1:0]   en3_x_missile_o,
  output logic [game_pkg::COORD_W-1:0]   en3_y_missile_o,
  output logic [game_pkg::LEVEL_W-1:0]   level_o
);

  logic                       run;
  logic [game_pkg::RGB_W-1:0] color;
  logic [3:0]                 speed;
  logic [2:0]                 alive;

  enemy_regs regs_i (
    .pclk(pclk), .rst_n_i(rst_n_i),
    .psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
    .paddr_i(paddr_i), .pwdata_i(pwdata_i), .prdata_o(prdata_o),
    .pready_o(pready_o), .pslverr_o(pslverr_o),
    .alive_i(alive), .level_i(level_o),  // status readback
    .run_o(run), .color_o(color), .speed_o(speed)
  );

  enemy_layer #(.ENEMY_SIZE(ENEMY_SIZE)) layer_i (
    .pclk(pclk), .rst_n_i(rst_n_i),
    .vcount_i(vcount_i), .vsync_i(vsync_i), .vblnk_i(vblnk_i),
    .hcount_i(hcount_i), .hsync_i(hsync_i), .hblnk_i(hblnk_i), .rgb_i(rgb_i),
    .vcount_o(vcount_o), .vsync_o(vsync_o), .vblnk_o(vblnk_o),
    .hcount_o(hcount_o), .hsync_o(hsync_o), .hblnk_o(hblnk_o), .rgb_o(rgb_o),
    .xpos_missile_i(xpos_missile_i), .ypos_missile_i(ypos_missile_i),
    .on_missile_i(on_missile_i),
    .run_i(run), .color_i(color), .speed_i(speed),
    .alive_o(alive), .level_o(level_o),
    .en1_x_missile_o(en1_x_missile_o), .en1_y_missile_o(en1_y_missile_o),
    .en2_x_missile_o(en2_x_missile_o), .en2_y_missile_o(en2_y_missile_o),
    .en3_x_missile_o(en3_x_missile_o), .en3_y_missile_o(en3_y_missile_o)
  );

endmodule

`default_nettype wire

// ==== tests/tb_support.svh ====
`ifndef TB_SUPPORT_SVH
`define TB_SUPPORT_SVH

// x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function automatic logic [31:0] rand_bits(int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    lfsr = lfsr_next(lfsr);  // one step per bit
    v = {v[30:0], lfsr[0]};
  end
  return v;
endfunction

task automatic timeout_abort(string what);
  $display("Timeout while waiting for %s at %0t", what, $time);
  $display("Verification failed");
  $finish;
endtask

// one APB transfer where data is the expected value of a read
task automatic apb_access(logic wr, logic [7:0] addr, logic [31:0] data, logic err);
  int n;
  @(posedge pclk);
  #1;
  psel_i    = 1'b1;  // setup
  penable_i = 1'b0;
  pwrite_i  = wr;
  paddr_i   = addr;
  pwdata_i  = data;
  @(posedge pclk);
  #1;
  penable_i = 1'b1;  // access
  apb_chk   = 1'b1;
  rd_chk    = !wr;
  exp_err   = err;
  exp_rdata = data;
  n = 0;
  while (!pready_o) begin
    if (n == 16) timeout_abort("APB pready_o");
    @(posedge pclk);
    #1;
    n++;
  end
  @(posedge pclk);
  #1;
  psel_i    = 1'b0;
  penable_i = 1'b0;
  apb_chk   = 1'b0;
  rd_chk    = 1'b0;
endtask

task automatic wait_level(logic [3:0] lvl);
  int n;
  n = 0;
  while (level_o !== lvl) begin
    if (n == 32) timeout_abort("the level to rise");
    @(posedge pclk);
    #1;
    n++;
  end
endtask

`endif

// ==== tests/enemy_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module enemy_tb;

  localparam int CW   = game_pkg::COORD_W;
  localparam int SIZE = 32;  // sprite side

  logic          pclk = 1'b0;
  logic          rst_n_i;
  logic          psel_i, penable_i, pwrite_i;
  logic [7:0]    paddr_i;
  logic [31:0]   pwdata_i, prdata_o;
  logic          pready_o, pslverr_o;
  logic [CW-1:0] vcount_i, hcount_i, vcount_o, hcount_o;
  logic          vsync_i, vblnk_i, hsync_i, hblnk_i;
  logic          vsync_o, vblnk_o, hsync_o, hblnk_o;
  logic [11:0]   rgb_i, rgb_o;
  logic [CW-1:0] xpos_missile_i, ypos_missile_i;
  logic          on_missile_i;
  logic [CW-1:0] en_x [1:3];
  logic [CW-1:0] en_y [1:3];
  logic [3:0]    level_o;

  logic [31:0] lfsr = 32'h8168;
  int          errors = 0;
  int          tests = 0;

  // checker controls driven along with the stimulus
  logic        px_chk, apb_chk, rd_chk, lvl_chk, move_chk;
  logic        exp_err;
  logic [11:0] exp_rgb;
  logic [31:0] exp_rdata;
  logic [3:0]  exp_level;

  // reference model of the enemies
  int          x_model [1:3];
  logic        dir_model [1:3];  // 1 moves right
  logic [3:1]  alive_model;
  int          level_model;
  int          speed_val;
  logic [11:0] color_val;

  always #10 pclk = ~pclk;

  enemy_top #(.ENEMY_SIZE(SIZE)) dut_i (
    .pclk(pclk), .rst_n_i(rst_n_i),
    .psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i), .paddr_i(paddr_i),
    .pwdata_i(pwdata_i), .prdata_o(prdata_o), .pready_o(pready_o), .pslverr_o(pslverr_o),
    .vcount_i(vcount_i), .vsync_i(vsync_i), .vblnk_i(vblnk_i),
    .hcount_i(hcount_i), .hsync_i(hsync_i), .hblnk_i(hblnk_i), .rgb_i(rgb_i),
    .vcount_o(vcount_o), .vsync_o(vsync_o), .vblnk_o(vblnk_o),
    .hcount_o(hcount_o), .hsync_o(hsync_o), .hblnk_o(hblnk_o), .rgb_o(rgb_o),
    .xpos_missile_i(xpos_missile_i), .ypos_missile_i(ypos_missile_i),
    .on_missile_i(on_missile_i),
    .en1_x_missile_o(en_x[1]), .en1_y_missile_o(en_y[1]),
    .en2_x_missile_o(en_x[2]), .en2_y_missile_o(en_y[2]),
    .en3_x_missile_o(en_x[3]), .en3_y_missile_o(en_y[3]),
    .level_o(level_o)
  );

  `include "tb_support.svh"

  function automatic void note_fail(string msg);
    $display("Fail at %0t: %s", $time, msg);
    errors++;
  endfunction

  function automatic logic [CW-1:0] next_missile_y(logic [CW-1:0] y, int e);
    int ny;
    ny = y + game_pkg::MISSILE_STEP;
    if (ny >= game_pkg::Y_LIMIT) return CW'(e * game_pkg::ROW_GAP + SIZE);  // reload
    return CW'(ny);
  endfunction

  // reload takes the centre of the square before this frame's step
  function automatic logic [CW-1:0] next_missile_x(logic [CW-1:0] y, logic [CW-1:0] x,
                                                   int left);
    if (y + game_pkg::MISSILE_STEP >= game_pkg::Y_LIMIT) return CW'(left + SIZE / 2);
    return x;
  endfunction

  function automatic logic in_square(int h, int v);
    logic found;
    found = 1'b0;
    for (int e = 1; e <= 3; e++) begin
      if (alive_model[e] && h >= x_model[e] && h < x_model[e] + SIZE &&
          v >= e * game_pkg::ROW_GAP && v < e * game_pkg::ROW_GAP + SIZE) found = 1'b1;
    end
    return found;
  endfunction

  function automatic logic [31:0] status_word();
    return {24'h0, 4'(level_model), 1'b0, alive_model};
  endfunction

  // three pipeline stages from input to output
  assert property (@(posedge pclk) disable iff (!rst_n_i)
    $past(px_chk, 3) |-> rgb_o == $past(exp_rgb, 3))
    else note_fail("rgb_o differs from expected pixel");

  assert property (@(posedge pclk) disable iff (!rst_n_i)
    $past(px_chk, 3) |-> vcount_o == $past(vcount_i, 3) && hcount_o == $past(hcount_i, 3) &&
      {vsync_o, vblnk_o, hsync_o, hblnk_o} == $past({vsync_i, vblnk_i, hsync_i, hblnk_i}, 3))
    else note_fail("video timing outputs not delayed by 3 cycles");

  assert property (@(posedge pclk) disable iff (!rst_n_i)
    apb_chk && pready_o |-> pslverr_o == exp_err)
    else note_fail("pslverr_o wrong");

  assert property (@(posedge pclk) disable iff (!rst_n_i)
    rd_chk && pready_o |-> prdata_o == exp_rdata)
    else note_fail("prdata_o wrong");

  assert property (@(posedge pclk) disable iff (!rst_n_i)
    lvl_chk |-> level_o == exp_level)
    else note_fail("level_o wrong");

  // unit e sees the vblnk edge e-1 cycles after the input
  for (genvar e = 1; e <= 3; e++) begin : g_missile
    assert property (@(posedge pclk) disable iff (!rst_n_i)
      $past(move_chk) && $past(vblnk_i, e) && !$past(vblnk_i, e + 1)
        |-> en_y[e] == next_missile_y($past(en_y[e]), e))
      else note_fail($sformatf("enemy %0d missile y wrong", e));

    assert property (@(posedge pclk) disable iff (!rst_n_i)
      $past(move_chk) && $past(vblnk_i, e) && !$past(vblnk_i, e + 1)
        |-> en_x[e] == next_missile_x($past(en_y[e]), $past(en_x[e]),
                                      $past(x_model[e], e)))
      else note_fail($sformatf("enemy %0d missile x wrong", e));
  end

  task automatic reset_model();
    for (int e = 1; e <= 3; e++) begin
      x_model[e]   = e * 200;
      dir_model[e] = 1'b1;
    end
    alive_model = 3'b111;
  endtask

  task automatic drive_pixel(int h, int v, logic [11:0] rgb, logic [3:0] syncs);
    @(posedge pclk);
    #1;
    hcount_i = CW'(h);
    vcount_i = CW'(v);
    rgb_i    = rgb;
    {vsync_i, vblnk_i, hsync_i, hblnk_i} = syncs;
    exp_rgb  = in_square(h, v) ? color_val : rgb;
    px_chk   = 1'b1;
  endtask

  task automatic idle(int n);
    repeat (n) begin
      @(posedge pclk);
      #1;
      px_chk = 1'b0;
    end
  endtask

  // a few pixels inside each enemy's current square
  task automatic square_pixels(int n);
    for (int e = 1; e <= 3; e++) begin
      repeat (n) drive_pixel(x_model[e] + rand_bits(5), e * game_pkg::ROW_GAP + rand_bits(5),
                             rand_bits(12), 4'b0000);
    end
    idle(4);
  endtask

  task automatic fire_missile(int e);
    @(posedge pclk);
    #1;
    px_chk         = 1'b0;
    xpos_missile_i = CW'(x_model[e] + 5);
    ypos_missile_i = CW'(e * game_pkg::ROW_GAP + 7);
    on_missile_i   = 1'b1;
    @(posedge pclk);
    #1;
    on_missile_i   = 1'b0;
    alive_model[e] = 1'b0;
  endtask

  // short frame with vblnk high for two cycles and low for two
  task automatic run_frame();
    int step;
    step = speed_val + level_model;
    repeat (2) drive_pixel(0, 800, rand_bits(12), 4'b0100);
    repeat (2) drive_pixel(0, 800, rand_bits(12), 4'b0000);
    for (int e = 1; e <= 3; e++) begin
      if (dir_model[e]) begin
        if (x_model[e] + step > game_pkg::X_MAX) begin
          x_model[e]   = game_pkg::X_MAX;
          dir_model[e] = 1'b0;
        end else x_model[e] += step;
      end else if (x_model[e] - step < game_pkg::X_MIN) begin
        x_model[e]   = game_pkg::X_MIN;
        dir_model[e] = 1'b1;
      end else x_model[e] -= step;
    end
  endtask

  task automatic end_test(string name, int mark);
    tests++;
    $display("test %0d %s done, %0d failed checks", tests, name, errors - mark);
  endtask

  initial begin
    int mark;
    rst_n_i = 1'b0;
    {psel_i, penable_i, pwrite_i, paddr_i, pwdata_i} = '0;
    {vcount_i, hcount_i, vsync_i, vblnk_i, hsync_i, hblnk_i, rgb_i} = '0;
    {xpos_missile_i, ypos_missile_i, on_missile_i} = '0;
    {px_chk, apb_chk, rd_chk, lvl_chk, move_chk, exp_err} = '0;
    exp_rgb   = '0;
    exp_rdata = '0;
    exp_level = '0;
    color_val = 12'hF00;  // reset values
    speed_val = 1;
    level_model = 0;
    reset_model();
    repeat (16) @(posedge pclk);
    #1;
    rst_n_i = 1'b1;
    lvl_chk = 1'b1;

    mark = errors;
    apb_access(1'b0, game_pkg::REG_STATUS, status_word(), 1'b0);
    apb_access(1'b1, game_pkg::REG_CTRL, 32'h1, 1'b0);
    apb_access(1'b0, game_pkg::REG_CTRL, 32'h1, 1'b0);
    apb_access(1'b1, game_pkg::REG_CTRL, 32'h0, 1'b0);
    apb_access(1'b1, game_pkg::REG_COLOR, 32'h3C7, 1'b0);
    color_val = 12'h3C7;
    apb_access(1'b0, game_pkg::REG_COLOR, 32'h3C7, 1'b0);
    apb_access(1'b1, game_pkg::REG_SPEED, 32'h3, 1'b0);
    speed_val = 3;
    apb_access(1'b0, game_pkg::REG_SPEED, 32'h3, 1'b0);
    apb_access(1'b1, 8'h10, 32'h5, 1'b1);  // unmapped
    apb_access(1'b0, 8'h10, 32'h0, 1'b1);
    apb_access(1'b1, game_pkg::REG_STATUS, 32'hFF, 1'b1);
    apb_access(1'b0, game_pkg::REG_STATUS, status_word(), 1'b0);
    end_test("register access", mark);

    mark = errors;
    repeat (60) drive_pixel(rand_bits(11), rand_bits(11), rand_bits(12), rand_bits(4));
    idle(4);
    end_test("video pass-through", mark);

    mark = errors;
    square_pixels(6);
    end_test("sprite overlay", mark);

    mark = errors;
    fire_missile(2);
    apb_access(1'b0, game_pkg::REG_STATUS, status_word(), 1'b0);
    square_pixels(4);  // enemy 2 now passes rgb through
    end_test("missile hit", mark);

    mark = errors;
    fire_missile(1);
    apb_access(1'b0, game_pkg::REG_STATUS, status_word(), 1'b0);
    lvl_chk = 1'b0;
    fire_missile(3);
    level_model++;
    reset_model();  // respawn
    wait_level(4'(level_model));
    exp_level = 4'(level_model);
    lvl_chk   = 1'b1;
    apb_access(1'b0, game_pkg::REG_STATUS, status_word(), 1'b0);
    square_pixels(3);
    end_test("level up", mark);

    mark = errors;
    apb_access(1'b1, game_pkg::REG_CTRL, 32'h1, 1'b0);
    move_chk = 1'b1;
    repeat (100) run_frame();  // long enough for reloads and a bounce
    move_chk = 1'b0;
    apb_access(1'b1, game_pkg::REG_CTRL, 32'h0, 1'b0);
    for (int e = 1; e <= 3; e++) begin
      drive_pixel(x_model[e] - 1, e * game_pkg::ROW_GAP + 9, rand_bits(12), 4'b0000);
      drive_pixel(x_model[e], e * game_pkg::ROW_GAP + 9, rand_bits(12), 4'b0000);
      drive_pixel(x_model[e] + SIZE - 1, e * game_pkg::ROW_GAP + 9, rand_bits(12), 4'b0000);
      drive_pixel(x_model[e] + SIZE, e * game_pkg::ROW_GAP + 9, rand_bits(12), 4'b0000);
    end
    idle(4);
    end_test("motion and enemy missiles", mark);

    $display("tests run %0d, failed checks %0d", tests, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+tests
design/game_pkg.sv
design/enemy_regs.sv
design/enemy_unit.sv
design/level_ctrl.sv
design/enemy_layer.sv
design/enemy_top.sv
tests/enemy_tb.sv
